/* rtl/pwm_pkg.sv */
/*
  Shared types and default widths for the two-channel PWM generator.
  The default widths only seed the top-level parameters; every module
  takes its actual widths from the parameters passed down from the top.
  Event and interrupt vectors share one bit order, so they line up bit for bit.
*/
package pwm_pkg;

  // Default counter/compare width and dead-band delay width
  localparam int CNT_W_DEF = 32;
  localparam int DB_W_DEF  = 12;

  // Shadow register update point
  typedef enum logic [1:0] {
    SYNC_ZERO   = 2'b00,
    SYNC_PERIOD = 2'b01,
    SYNC_BOTH   = 2'b10,
    SYNC_END    = 2'b11
  } sync_mode_e;

  // One-cycle counter events, split by count direction for the compares
  typedef struct packed {
    logic cnt_zero;
    logic cnt_load;
    logic cmpa_up;
    logic cmpa_down;
    logic cmpb_up;
    logic cmpb_down;
  } pwm_event_t;

  // Per-channel control
  typedef struct packed {
    logic en;
    logic inv;
  } pwm_chan_t;

  // Interrupt enable, clear and flag vectors
  typedef struct packed {
    logic cnt_zero;
    logic cnt_load;
    logic cmpa_up;
    logic cmpa_down;
    logic cmpb_up;
    logic cmpb_down;
  } pwm_irq_t;

endpackage

/* rtl/pwm_shadow.sv */
/*
  Shadow registers for period and the two compare values.
  While both channels are off the shadows follow the live inputs every
  cycle. Once running, they load only on the selected sync point, so a
  new value takes effect from the count after that point.
  The counter markers must already be qualified by activity.
*/
`timescale 1ns/100ps

module pwm_shadow #(
  parameter int CNT_W = 32
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   i_active,
  input  pwm_pkg::sync_mode_e    i_sync_mode,
  input  logic                   i_at_zero,
  input  logic                   i_at_period,
  input  logic                   i_at_end,
  input  logic [CNT_W-1:0]       i_period_val,
  input  logic [CNT_W-1:0]       i_cmp_a_val,
  input  logic [CNT_W-1:0]       i_cmp_b_val,
  output logic [CNT_W-1:0]       o_period,
  output logic [CNT_W-1:0]       o_cmp_a,
  output logic [CNT_W-1:0]       o_cmp_b
);

  logic upd_sync;
  logic upd;

  // Sync mode selects which counter marker opens the shadows
  always_comb begin
    case (i_sync_mode)
      pwm_pkg::SYNC_ZERO:   upd_sync = i_at_zero;
      pwm_pkg::SYNC_PERIOD: upd_sync = i_at_period;
      pwm_pkg::SYNC_BOTH:   upd_sync = i_at_zero | i_at_period;
      pwm_pkg::SYNC_END:    upd_sync = i_at_end;
      default:              upd_sync = 1'b0;
    endcase
  end

  assign upd = upd_sync | ~i_active;

  // Period resets to all ones so an idle counter never wraps early
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_period <= '1;
    end else if (upd) begin
      o_period <= i_period_val;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_cmp_a <= '0;
    end else if (upd) begin
      o_cmp_a <= i_cmp_a_val;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_cmp_b <= '0;
    end else if (upd) begin
      o_cmp_b <= i_cmp_b_val;
    end
  end

endmodule

/* rtl/pwm_counter.sv */
/*
  PWM time base.
  Up mode counts 0..period and wraps. Up-down mode turns down at
  period-1 and up again when the down ramp reaches 1, so the peak is the
  period and the valley is 0. A period of 0 holds the count at 0.
  When both channels are off the count is 0 and the direction is up.
*/
`timescale 1ns/100ps

module pwm_counter #(
  parameter int CNT_W = 32
) (
  input  logic                clk,
  input  logic                rstn,
  input  pwm_pkg::pwm_chan_t  i_chan_a,
  input  pwm_pkg::pwm_chan_t  i_chan_b,
  input  logic                i_updown,
  input  logic [CNT_W-1:0]    i_period,
  input  logic [CNT_W-1:0]    i_cmp_a,
  input  logic [CNT_W-1:0]    i_cmp_b,
  output logic [CNT_W-1:0]    o_cnt,
  output logic                o_up,
  output logic                o_active,
  output logic                o_at_zero,
  output logic                o_at_period,
  output logic                o_at_end,
  output pwm_pkg::pwm_event_t o_evt
);

  localparam logic [CNT_W-1:0] ONE = CNT_W'(1);

  logic hit_a;
  logic hit_b;

  assign o_active = i_chan_a.en | i_chan_b.en;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_cnt <= '0;
    end else if (!o_active) begin
      o_cnt <= '0;
    end else if (!i_updown) begin
      o_cnt <= (o_cnt == i_period) ? '0 : o_cnt + ONE;
    end else if (i_period == '0) begin
      o_cnt <= '0;
    end else begin
      o_cnt <= o_up ? o_cnt + ONE : o_cnt - ONE;
    end
  end

  // Direction turns one step early so the turn count itself is the peak
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_up <= 1'b1;
    end else if (!o_active || !i_updown) begin
      o_up <= 1'b1;
    end else if (o_cnt == i_period - ONE) begin
      o_up <= 1'b0;
    end else if (!o_up && o_cnt == ONE) begin
      o_up <= 1'b1;
    end
  end

  assign o_at_zero   = o_active && (o_cnt == '0);
  assign o_at_period = o_active && (o_cnt == i_period);
  assign o_at_end    = i_updown ? (o_active && !o_up && o_cnt == ONE) : o_at_period;

  assign hit_a = o_active && (o_cnt == i_cmp_a);
  assign hit_b = o_active && (o_cnt == i_cmp_b);

  always_comb begin
    o_evt.cnt_zero  = o_at_zero;
    o_evt.cnt_load  = o_at_period;
    o_evt.cmpa_up   = hit_a & o_up;
    o_evt.cmpa_down = hit_a & ~o_up;
    o_evt.cmpb_up   = hit_b & o_up;
    o_evt.cmpb_down = hit_b & ~o_up;
  end

endmodule

/* rtl/pwm_waveform.sv */
/*
  Compare outputs, dead-band pair, inversion and output enables.
  The pin outputs are registered and lag the count by one cycle.
  In dead-band mode both pins derive from channel A only: A rises after
  raw A has been high for delay+1 cycles, B is its delayed complement.
  Output enables follow the channel enables and ignore dead-band mode.
*/
`timescale 1ns/100ps

module pwm_waveform #(
  parameter int CNT_W = 32,
  parameter int DB_W  = 12
) (
  input  logic               clk,
  input  logic               rstn,
  input  pwm_pkg::pwm_chan_t i_chan_a,
  input  pwm_pkg::pwm_chan_t i_chan_b,
  input  logic               i_active,
  input  logic               i_up,
  input  logic [CNT_W-1:0]   i_cnt,
  input  logic [CNT_W-1:0]   i_cmp_a,
  input  logic [CNT_W-1:0]   i_cmp_b,
  input  logic               i_db_en,
  input  logic [DB_W-1:0]    i_db_delay,
  output logic               o_pwm_a,
  output logic               o_pwm_b,
  output logic               o_oe_a,
  output logic               o_oe_b
);

  logic            raw_a;
  logic            raw_b;
  logic            pwm_a_q;
  logic            pwm_b_q;
  logic [DB_W-1:0] db_cnt_a;
  logic [DB_W-1:0] db_cnt_b;
  logic            db_a;
  logic            db_b;
  logic            pre_a;
  logic            pre_b;

  // Inclusive compare on the way up, exclusive on the way down
  assign raw_a = i_chan_a.en && ((i_up && i_cnt >= i_cmp_a) || (!i_up && i_cnt > i_cmp_a));
  assign raw_b = i_chan_b.en && ((i_up && i_cnt >= i_cmp_b) || (!i_up && i_cnt > i_cmp_b));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pwm_a_q <= 1'b0;
      pwm_b_q <= 1'b0;
    end else begin
      pwm_a_q <= raw_a;
      pwm_b_q <= raw_b;
    end
  end

  // Time raw A high for the A edge and raw A low for the B edge
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      db_cnt_a <= '0;
    end else if (!i_active || !raw_a || db_cnt_a == i_db_delay) begin
      db_cnt_a <= '0;
    end else begin
      db_cnt_a <= db_cnt_a + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      db_cnt_b <= '0;
    end else if (!i_active || raw_a || db_cnt_b == i_db_delay) begin
      db_cnt_b <= '0;
    end else begin
      db_cnt_b <= db_cnt_b + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      db_a <= 1'b0;
    end else if (!i_active || (!raw_a && pwm_a_q)) begin
      db_a <= 1'b0;
    end else if (raw_a && db_cnt_a == i_db_delay) begin
      db_a <= 1'b1;
    end
  end

  // Complement idles high
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      db_b <= 1'b1;
    end else if (!i_active) begin
      db_b <= 1'b1;
    end else if (raw_a && !pwm_a_q) begin
      db_b <= 1'b0;
    end else if (!raw_a && db_cnt_b == i_db_delay) begin
      db_b <= 1'b1;
    end
  end

  assign pre_a = i_db_en ? db_a : pwm_a_q;
  assign pre_b = i_db_en ? db_b : pwm_b_q;

  assign o_pwm_a = pre_a ^ i_chan_a.inv;
  assign o_pwm_b = pre_b ^ i_chan_b.inv;
  assign o_oe_a  = i_chan_a.en;
  assign o_oe_b  = i_chan_b.en;

endmodule

/* rtl/pwm_irq.sv */
/*
  Sticky interrupt flags.
  Each flag sets on the clock after its event pulse falls, so a flag
  appears about two cycles after the count that raised the event.
  A flag sets only while its enable bit is high and stays set until its
  clear bit is pulsed; clear wins over a set in the same cycle.
*/
`timescale 1ns/100ps

module pwm_irq (
  input  logic                clk,
  input  logic                rstn,
  input  pwm_pkg::pwm_event_t i_evt,
  input  pwm_pkg::pwm_irq_t   i_irq_en,
  input  pwm_pkg::pwm_irq_t   i_irq_clr,
  output pwm_pkg::pwm_irq_t   o_irq
);

  pwm_pkg::pwm_event_t evt_q;
  logic [5:0]          evt_fall;
  logic [5:0]          irq_set;
  logic [5:0]          irq_nxt;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      evt_q <= '0;
    end else begin
      evt_q <= i_evt;
    end
  end

  // Falling edge of each event, same bit order as the flag vector
  assign evt_fall = evt_q & ~i_evt;
  assign irq_set  = evt_fall & i_irq_en;
  assign irq_nxt  = (o_irq | irq_set) & ~i_irq_clr;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_irq <= '0;
    end else begin
      o_irq <= pwm_pkg::pwm_irq_t'(irq_nxt);
    end
  end

endmodule

/* rtl/pwm_top.sv */
/*
  Two-channel PWM generator, single clock.
  Shadow update, counter, waveform stage and interrupt flags.
  CNT_W sets the counter and compare width, DB_W the dead-band delay.
  Compare and period inputs are sampled into shadows and take effect
  at the selected sync point once a channel is enabled.
*/
`timescale 1ns/100ps

module pwm_top #(
  parameter int CNT_W = pwm_pkg::CNT_W_DEF,
  parameter int DB_W  = pwm_pkg::DB_W_DEF
) (
  input  logic                clk,
  input  logic                rstn,
  input  pwm_pkg::pwm_chan_t  i_chan_a,
  input  pwm_pkg::pwm_chan_t  i_chan_b,
  input  logic                i_updown,
  input  pwm_pkg::sync_mode_e i_sync_mode,
  input  logic [CNT_W-1:0]    i_period_val,
  input  logic [CNT_W-1:0]    i_cmp_a_val,
  input  logic [CNT_W-1:0]    i_cmp_b_val,
  input  logic                i_db_en,
  input  logic [DB_W-1:0]     i_db_delay,
  input  pwm_pkg::pwm_irq_t   i_irq_en,
  input  pwm_pkg::pwm_irq_t   i_irq_clr,
  output logic [CNT_W-1:0]    o_cnt,
  output logic                o_pwm_a,
  output logic                o_pwm_b,
  output logic                o_oe_a,
  output logic                o_oe_b,
  output pwm_pkg::pwm_irq_t   o_irq
);

  logic [CNT_W-1:0]    period;
  logic [CNT_W-1:0]    cmp_a;
  logic [CNT_W-1:0]    cmp_b;
  logic                up;
  logic                active;
  logic                at_zero;
  logic                at_period;
  logic                at_end;
  pwm_pkg::pwm_event_t evt;

  pwm_shadow #(
    .CNT_W (CNT_W)
  ) u_shadow (
    .clk          (clk),
    .rstn         (rstn),
    .i_active     (active),
    .i_sync_mode  (i_sync_mode),
    .i_at_zero    (at_zero),
    .i_at_period  (at_period),
    .i_at_end     (at_end),
    .i_period_val (i_period_val),
    .i_cmp_a_val  (i_cmp_a_val),
    .i_cmp_b_val  (i_cmp_b_val),
    .o_period     (period),
    .o_cmp_a      (cmp_a),
    .o_cmp_b      (cmp_b)
  );

  pwm_counter #(
    .CNT_W (CNT_W)
  ) u_counter (
    .clk         (clk),
    .rstn        (rstn),
    .i_chan_a    (i_chan_a),
    .i_chan_b    (i_chan_b),
    .i_updown    (i_updown),
    .i_period    (period),
    .i_cmp_a     (cmp_a),
    .i_cmp_b     (cmp_b),
    .o_cnt       (o_cnt),
    .o_up        (up),
    .o_active    (active),
    .o_at_zero   (at_zero),
    .o_at_period (at_period),
    .o_at_end    (at_end),
    .o_evt       (evt)
  );

  pwm_waveform #(
    .CNT_W (CNT_W),
    .DB_W  (DB_W)
  ) u_waveform (
    .clk        (clk),
    .rstn       (rstn),
    .i_chan_a   (i_chan_a),
    .i_chan_b   (i_chan_b),
    .i_active   (active),
    .i_up       (up),
    .i_cnt      (o_cnt),
    .i_cmp_a    (cmp_a),
    .i_cmp_b    (cmp_b),
    .i_db_en    (i_db_en),
    .i_db_delay (i_db_delay),
    .o_pwm_a    (o_pwm_a),
    .o_pwm_b    (o_pwm_b),
    .o_oe_a     (o_oe_a),
    .o_oe_b     (o_oe_b)
  );

  pwm_irq u_irq (
    .clk       (clk),
    .rstn      (rstn),
    .i_evt     (evt),
    .i_irq_en  (i_irq_en),
    .i_irq_clr (i_irq_clr),
    .o_irq     (o_irq)
  );

endmodule

/* verif/pwm_properties.sv */
/*
  Concurrent checks bound into every pwm_top instance.
  The dead-band overlap check applies only with both inversions off.
  The flag check compares each newly set flag with the enable seen
  at the clock edge that set it.
*/
`timescale 1ns/100ps

module pwm_properties #(
  parameter int CNT_W = 32
) (
  input logic               clk,
  input logic               rstn,
  input pwm_pkg::pwm_chan_t i_chan_a,
  input pwm_pkg::pwm_chan_t i_chan_b,
  input logic               i_db_en,
  input logic               i_pwm_a,
  input logic               i_pwm_b,
  input logic [CNT_W-1:0]   i_cnt,
  input logic [CNT_W-1:0]   i_period,
  input logic [5:0]         i_irq_en,
  input logic [5:0]         i_irq
);

  a_db_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
    (i_db_en && !i_chan_a.inv && !i_chan_b.inv) |-> !(i_pwm_a && i_pwm_b))
    else $error("dead-band outputs were high together");

  a_cnt_in_range: assert property (@(posedge clk) disable iff (!rstn)
    i_cnt <= i_period)
    else $error("count went above the shadow period");

  // A newly set flag needs its enable at the setting edge
  a_irq_gated: assert property (@(posedge clk) disable iff (!rstn)
    (i_irq & ~$past(i_irq) & ~$past(i_irq_en)) == 6'b0)
    else $error("interrupt flag set while its enable was clear");

endmodule

bind pwm_top pwm_properties #(
  .CNT_W (CNT_W)
) u_props (
  .clk      (clk),
  .rstn     (rstn),
  .i_chan_a (i_chan_a),
  .i_chan_b (i_chan_b),
  .i_db_en  (i_db_en),
  .i_pwm_a  (o_pwm_a),
  .i_pwm_b  (o_pwm_b),
  .i_cnt    (o_cnt),
  .i_period (period),
  .i_irq_en (i_irq_en),
  .i_irq    (o_irq)
);

/* verif/tb_pwm.sv */
/*
  Table-driven testbench for pwm_top with CNT_W 16 and DB_W 8.
  A behavioral model predicts count, pin outputs, output enables and flags
  every cycle. Each row first disables both channels for two cycles so the
  shadows pick up the row's values and all flags are cleared.
  Rows that change the period mid-run must use SYNC_ZERO or up mode.
*/
`timescale 1ns/100ps

module tb_pwm;

  typedef struct packed {
    logic                updown;
    logic [15:0]         period;
    logic [15:0]         period2;
    logic [15:0]         chg_at;
    logic [15:0]         cmp_a;
    logic [15:0]         cmp_b;
    pwm_pkg::sync_mode_e sync;
    logic                db_en;
    logic [7:0]          db_delay;
    pwm_pkg::pwm_chan_t  chan_a;
    pwm_pkg::pwm_chan_t  chan_b;
    logic [5:0]          irq_en;
    logic [15:0]         cycles;
  } row_t;

  logic                clk = 1'b0;
  logic                rstn;
  pwm_pkg::pwm_chan_t  chan_a;
  pwm_pkg::pwm_chan_t  chan_b;
  logic                updown;
  pwm_pkg::sync_mode_e sync_mode;
  logic [15:0]         period_val;
  logic [15:0]         cmp_a_val;
  logic [15:0]         cmp_b_val;
  logic                db_en;
  logic [7:0]          db_delay;
  logic [5:0]          irq_en;
  logic [5:0]          irq_clr;
  logic [15:0]         cnt;
  logic                pwm_a;
  logic                pwm_b;
  logic                oe_a;
  logic                oe_b;
  logic [5:0]          irq;

  row_t        rows[$];
  string       names[$];
  string       cur_name;
  int          row_errs;
  int          errs = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          timeout_lim = 100000;
  logic [31:0] rng_state = 32'h95e0438f;

  // Model state
  int         m_cnt;
  logic       m_up;
  int         m_per;
  int         m_ca;
  int         m_cb;
  logic       m_pa_q;
  logic       m_pb_q;
  logic       m_dba;
  logic       m_dbb;
  int         hi_run;
  int         lo_run;
  logic [5:0] m_irq;
  logic [5:0] m_evt_q;

  pwm_top #(
    .CNT_W (16),
    .DB_W  (8)
  ) DUT (
    .clk          (clk),
    .rstn         (rstn),
    .i_chan_a     (chan_a),
    .i_chan_b     (chan_b),
    .i_updown     (updown),
    .i_sync_mode  (sync_mode),
    .i_period_val (period_val),
    .i_cmp_a_val  (cmp_a_val),
    .i_cmp_b_val  (cmp_b_val),
    .i_db_en      (db_en),
    .i_db_delay   (db_delay),
    .i_irq_en     (irq_en),
    .i_irq_clr    (irq_clr),
    .o_cnt        (cnt),
    .o_pwm_a      (pwm_a),
    .o_pwm_b      (pwm_b),
    .o_oe_a       (oe_a),
    .o_oe_b       (oe_b),
    .o_irq        (irq)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > timeout_lim) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_lim);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic add_row(string name, logic ud, int per, int per2, int chg, int ca, int cb,
                         pwm_pkg::sync_mode_e sm, logic dbe, int dly,
                         pwm_pkg::pwm_chan_t ca_ctl, pwm_pkg::pwm_chan_t cb_ctl,
                         logic [5:0] ien, int cyc);
    row_t r;
    r.updown   = ud;
    r.period   = 16'(per);
    r.period2  = 16'(per2);
    r.chg_at   = 16'(chg);
    r.cmp_a    = 16'(ca);
    r.cmp_b    = 16'(cb);
    r.sync     = sm;
    r.db_en    = dbe;
    r.db_delay = 8'(dly);
    r.chan_a   = ca_ctl;
    r.chan_b   = cb_ctl;
    r.irq_en   = ien;
    r.cycles   = 16'(cyc);
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic add_random_row(string name);
    logic [31:0] r;
    logic [31:0] s;
    int          per;
    r = lcg_next();
    s = lcg_next();
    per = 4 + int'(r[19:16]);
    add_row(name, r[31], per, per, 0, int'(s[23:16]) % (per + 1), int'(s[31:24]) % (per + 1),
            pwm_pkg::sync_mode_e'(r[21:20]), r[22], int'(r[24:23]), {1'b1, r[25]},
            {r[26], r[27]}, s[13:8], 64);
  endtask

  task automatic model_step();
    logic       act;
    logic       raw_a;
    logic       raw_b;
    logic       upd;
    logic [5:0] evt;
    int         dly;
    int         nxt;
    act = chan_a.en || chan_b.en;
    dly = int'(db_delay);
    raw_a = chan_a.en && (m_up ? m_cnt >= m_ca : m_cnt > m_ca);
    raw_b = chan_b.en && (m_up ? m_cnt >= m_cb : m_cnt > m_cb);
    evt[5] = act && m_cnt == 0;
    evt[4] = act && m_cnt == m_per;
    evt[3] = act && m_cnt == m_ca && m_up;
    evt[2] = act && m_cnt == m_ca && !m_up;
    evt[1] = act && m_cnt == m_cb && m_up;
    evt[0] = act && m_cnt == m_cb && !m_up;
    case (sync_mode)
      pwm_pkg::SYNC_ZERO:   upd = evt[5];
      pwm_pkg::SYNC_PERIOD: upd = evt[4];
      pwm_pkg::SYNC_BOTH:   upd = evt[5] | evt[4];
      default:              upd = updown ? (act && !m_up && m_cnt == 1) : evt[4];
    endcase
    // Flags set one clock after the event falls and clear wins
    m_irq = (m_irq | (m_evt_q & ~evt & irq_en)) & ~irq_clr;
    m_evt_q = evt;
    // Dead band from run lengths of raw A
    if (!act) begin
      hi_run = 0;
      lo_run = 0;
      m_dba = 1'b0;
      m_dbb = 1'b1;
    end else if (raw_a) begin
      hi_run = hi_run + 1;
      lo_run = 0;
      m_dba = hi_run > dly;
      m_dbb = 1'b0;
    end else begin
      lo_run = lo_run + 1;
      hi_run = 0;
      m_dba = 1'b0;
      if (lo_run > dly) begin
        m_dbb = 1'b1;
      end
    end
    m_pa_q = raw_a;
    m_pb_q = raw_b;
    // Counter uses the old shadow period
    if (!act) begin
      m_cnt = 0;
      m_up = 1'b1;
    end else if (!updown) begin
      m_cnt = (m_cnt == m_per) ? 0 : m_cnt + 1;
      m_up = 1'b1;
    end else begin
      // Step follows the direction held before this edge
      if (m_per == 0) begin
        nxt = 0;
      end else begin
        nxt = m_up ? m_cnt + 1 : m_cnt - 1;
      end
      if (m_cnt == m_per - 1) begin
        m_up = 1'b0;
      end else if (!m_up && m_cnt == 1) begin
        m_up = 1'b1;
      end
      m_cnt = nxt;
    end
    if (upd || !act) begin
      m_per = int'(period_val);
      m_ca = int'(cmp_a_val);
      m_cb = int'(cmp_b_val);
    end
  endtask

  task automatic check_val(string what, int got, int exp);
    checks++;
    assert (got == exp) else begin
      $display("Fail %0t: %s %s got %0d expected %0d", $time, cur_name, what, got, exp);
      row_errs++;
      errs++;
    end
  endtask

  task automatic check_outputs();
    logic exp_a;
    logic exp_b;
    exp_a = (db_en ? m_dba : m_pa_q) ^ chan_a.inv;
    exp_b = (db_en ? m_dbb : m_pb_q) ^ chan_b.inv;
    check_val("count", int'(cnt), m_cnt);
    check_val("pwm_a", int'(pwm_a), int'(exp_a));
    check_val("pwm_b", int'(pwm_b), int'(exp_b));
    check_val("oe_a", int'(oe_a), int'(chan_a.en));
    check_val("oe_b", int'(oe_b), int'(chan_b.en));
    check_val("irq", int'(irq), int'(m_irq));
  endtask

  task automatic apply_row(row_t r, logic run);
    chan_a = r.chan_a;
    chan_b = r.chan_b;
    chan_a.en = r.chan_a.en & run;
    chan_b.en = r.chan_b.en & run;
    updown = r.updown;
    sync_mode = r.sync;
    period_val = r.period;
    cmp_a_val = r.cmp_a;
    cmp_b_val = r.cmp_b;
    db_en = r.db_en;
    db_delay = r.db_delay;
    irq_en = r.irq_en;
  endtask

  task automatic run_row(int idx);
    row_t r;
    r = rows[idx];
    cur_name = names[idx];
    row_errs = 0;
    for (int c = 0; c < 2; c++) begin
      @(negedge clk);
      check_outputs();
      apply_row(r, 1'b0);
      irq_clr = '1;
      model_step();
    end
    for (int c = 0; c < int'(r.cycles); c++) begin
      @(negedge clk);
      check_outputs();
      apply_row(r, 1'b1);
      irq_clr = '0;
      if (c >= int'(r.chg_at)) begin
        period_val = r.period2;
      end
      model_step();
    end
    $display("test %s: %s, %0d errors", cur_name, (row_errs == 0) ? "ok" : "mismatch",
             row_errs);
  endtask

  initial begin
    rstn = 1'b0;
    chan_a = '0;
    chan_b = '0;
    updown = 1'b0;
    sync_mode = pwm_pkg::SYNC_ZERO;
    period_val = '0;
    cmp_a_val = '0;
    cmp_b_val = '0;
    db_en = 1'b0;
    db_delay = '0;
    irq_en = '0;
    irq_clr = '0;
    m_cnt = 0;
    m_up = 1'b1;
    m_per = 16'hffff;
    m_ca = 0;
    m_cb = 0;
    m_pa_q = 1'b0;
    m_pb_q = 1'b0;
    m_dba = 1'b0;
    m_dbb = 1'b1;
    hi_run = 0;
    lo_run = 0;
    m_irq = '0;
    m_evt_q = '0;

    add_row("up_basic", 1'b0, 9, 9, 0, 4, 7, pwm_pkg::SYNC_PERIOD, 1'b0, 0,
            2'b10, 2'b10, 6'h3f, 40);
    add_row("updown_basic", 1'b1, 8, 8, 0, 3, 6, pwm_pkg::SYNC_ZERO, 1'b0, 0,
            2'b10, 2'b10, 6'b110011, 50);
    add_row("sync_zero_change", 1'b0, 7, 12, 13, 3, 5, pwm_pkg::SYNC_ZERO, 1'b0, 0,
            2'b10, 2'b10, 6'h30, 50);
    add_row("deadband_up", 1'b0, 15, 15, 0, 6, 0, pwm_pkg::SYNC_BOTH, 1'b1, 2,
            2'b10, 2'b10, 6'h0c, 60);
    add_row("deadband_updown", 1'b1, 12, 12, 0, 5, 9, pwm_pkg::SYNC_END, 1'b1, 3,
            2'b10, 2'b00, 6'h3f, 60);
    add_row("invert_a_only", 1'b0, 10, 10, 0, 3, 8, pwm_pkg::SYNC_PERIOD, 1'b0, 0,
            2'b11, 2'b01, 6'h00, 40);
    add_row("sync_end_updown", 1'b1, 6, 6, 0, 2, 4, pwm_pkg::SYNC_END, 1'b0, 0,
            2'b11, 2'b11, 6'h0f, 40);
    add_row("period_zero", 1'b0, 0, 0, 0, 0, 0, pwm_pkg::SYNC_ZERO, 1'b0, 0,
            2'b10, 2'b10, 6'h3f, 12);
    add_random_row("random_0");
    add_random_row("random_1");

    timeout_lim = 50;
    foreach (rows[i]) begin
      timeout_lim += int'(rows[i].cycles) + 2;
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    model_step();
    foreach (rows[i]) begin
      run_row(i);
    end
    @(negedge clk);
    check_outputs();
    $display("%0d tests, %0d checks, %0d errors", rows.size(), checks, errs);
    if (errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
rtl/pwm_pkg.sv
rtl/pwm_shadow.sv
rtl/pwm_counter.sv
rtl/pwm_waveform.sv
rtl/pwm_irq.sv
rtl/pwm_top.sv
verif/pwm_properties.sv
verif/tb_pwm.sv

/* Makefile */
# Verilator simulation of the PWM testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_pwm
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_STR  ?= STATUS: PASS

.PHONY: sim clean

# The run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
